// ==== src/trace_monitor_pkg.sv ====
package trace_monitor_pkg;

  // Datapath widths of the retirement record
  localparam int unsigned XLEN        = 32;
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned CAUSE_W     = 11;
  localparam int unsigned DBG_CAUSE_W = 3;
  localparam int unsigned MASK_W      = 4;

  // Cause field of dcsr sits at bits [8:6]
  localparam int unsigned DCSR_CAUSE_LSB = 6;

  // Reported accesses per record, read plus write
  localparam int unsigned MEM_CNT_W = 2;

  // Event counters saturate at all ones
  localparam int unsigned CNT_W = 16;

  // Violation vector and code widths
  localparam int unsigned NUM_VIOL    = 11;
  localparam int unsigned VIOL_CODE_W = 4;

  // Violation bit positions, lowest index wins the first code
  localparam int unsigned V_RS_RESET         = 0;
  localparam int unsigned V_DBG_CAUSE        = 1;
  localparam int unsigned V_EXC_CAUSE        = 2;
  localparam int unsigned V_EXC_MCAUSE_INT   = 3;
  localparam int unsigned V_IRQ_CAUSE        = 4;
  localparam int unsigned V_HANDLER_AMBIG    = 5;
  localparam int unsigned V_SYNC_UNANNOUNCED = 6;
  localparam int unsigned V_MISSING_CAUSE    = 7;
  localparam int unsigned V_STORE_MASK       = 8;
  localparam int unsigned V_MEM_OVERREPORT   = 9;
  localparam int unsigned V_IRQ_OVERREPORT   = 10;

  // CLINT interrupt causes: software, timer, external
  localparam int unsigned CLINT_CAUSE_MSI = 3;
  localparam int unsigned CLINT_CAUSE_MTI = 7;
  localparam int unsigned CLINT_CAUSE_MEI = 11;

  // CLINT fast interrupt range
  localparam int unsigned CLINT_FAST_LO = 16;
  localparam int unsigned CLINT_FAST_HI = 31;

  // Platform causes, legal under either scheme
  localparam int unsigned PLAT_CAUSE_LO = 1024;
  localparam int unsigned PLAT_CAUSE_HI = 1027;

endpackage

// ==== src/trace_decode.sv ====
`timescale 1ns/10ps

module trace_decode (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        rec_valid,
  input  logic [trace_monitor_pkg::REG_ADDR_W-1:0]    rec_rs1_addr,
  input  logic [trace_monitor_pkg::REG_ADDR_W-1:0]    rec_rs2_addr,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_rs1_rdata,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_rs2_rdata,
  input  logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   rec_dbg,
  input  logic                                        rec_dbg_mode,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_dcsr_rdata,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_mcause_wdata,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_mcause_wmask,
  input  logic                                        rec_trap_exception,
  input  logic [trace_monitor_pkg::CAUSE_W-1:0]       rec_trap_exc_cause,
  input  logic                                        rec_trap_debug,
  input  logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   rec_trap_dbg_cause,
  input  logic                                        rec_intr_interrupt,
  input  logic                                        rec_intr_exception,
  input  logic [trace_monitor_pkg::CAUSE_W-1:0]       rec_intr_cause,
  input  logic [trace_monitor_pkg::MASK_W-1:0]        rec_mem_rmask,
  input  logic [trace_monitor_pkg::MASK_W-1:0]        rec_mem_wmask,
  input  logic                                        rec_is_store,
  output logic                                        d_valid,
  output logic [trace_monitor_pkg::REG_ADDR_W-1:0]    d_rs1_addr,
  output logic [trace_monitor_pkg::REG_ADDR_W-1:0]    d_rs2_addr,
  output logic [trace_monitor_pkg::XLEN-1:0]          d_rs1_rdata,
  output logic [trace_monitor_pkg::XLEN-1:0]          d_rs2_rdata,
  output logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   d_dbg,
  output logic                                        d_dbg_mode,
  output logic                                        d_mcause_int_wdata,
  output logic                                        d_mcause_int_wmask,
  output logic                                        d_trap_exception,
  output logic [trace_monitor_pkg::CAUSE_W-1:0]       d_trap_exc_cause,
  output logic                                        d_trap_debug,
  output logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   d_trap_dbg_cause,
  output logic                                        d_intr_interrupt,
  output logic                                        d_intr_exception,
  output logic [trace_monitor_pkg::CAUSE_W-1:0]       d_intr_cause,
  output logic [trace_monitor_pkg::MASK_W-1:0]        d_mem_wmask,
  output logic                                        d_is_store,
  output logic [trace_monitor_pkg::CAUSE_W-1:0]       d_exccode,
  output logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   d_dcsr_cause,
  output logic [trace_monitor_pkg::MEM_CNT_W-1:0]     d_mem_cnt
);
  import trace_monitor_pkg::*;

  // Only the bits of mcause that are actually written
  logic [XLEN-1:0] masked_mcause;

  assign masked_mcause = rec_mcause_wdata & rec_mcause_wmask;

  // Record strobe is the only control bit here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= rec_valid;
    end
  end

  // Record payload, qualified downstream by d_valid
  always_ff @(posedge clk_i) begin
    d_rs1_addr         <= rec_rs1_addr;
    d_rs2_addr         <= rec_rs2_addr;
    d_rs1_rdata        <= rec_rs1_rdata;
    d_rs2_rdata        <= rec_rs2_rdata;
    d_dbg              <= rec_dbg;
    d_dbg_mode         <= rec_dbg_mode;
    d_trap_exception   <= rec_trap_exception;
    d_trap_exc_cause   <= rec_trap_exc_cause;
    d_trap_debug       <= rec_trap_debug;
    d_trap_dbg_cause   <= rec_trap_dbg_cause;
    d_intr_interrupt   <= rec_intr_interrupt;
    d_intr_exception   <= rec_intr_exception;
    d_intr_cause       <= rec_intr_cause;
    d_mem_wmask        <= rec_mem_wmask;
    d_is_store         <= rec_is_store;
    // mcause.interrupt bit as written and as enabled
    d_mcause_int_wdata <= rec_mcause_wdata[XLEN-1];
    d_mcause_int_wmask <= rec_mcause_wmask[XLEN-1];
    // Exception code is the low field of the masked write
    d_exccode          <= masked_mcause[CAUSE_W-1:0];
    d_dcsr_cause       <= rec_dcsr_rdata[DCSR_CAUSE_LSB +: DBG_CAUSE_W];
    // One access per nonzero mask, none when no record
    d_mem_cnt          <= MEM_CNT_W'(rec_valid && (|rec_mem_rmask)) +
                          MEM_CNT_W'(rec_valid && (|rec_mem_wmask));
  end

endmodule

// ==== src/trace_rule_check.sv ====
`timescale 1ns/10ps

module trace_rule_check #(
  parameter bit          clic          = 1'b0,
  parameter int unsigned clic_id_width = 5
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        d_valid,
  input  logic [trace_monitor_pkg::REG_ADDR_W-1:0]    d_rs1_addr,
  input  logic [trace_monitor_pkg::REG_ADDR_W-1:0]    d_rs2_addr,
  input  logic [trace_monitor_pkg::XLEN-1:0]          d_rs1_rdata,
  input  logic [trace_monitor_pkg::XLEN-1:0]          d_rs2_rdata,
  input  logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   d_dbg,
  input  logic                                        d_dbg_mode,
  input  logic                                        d_mcause_int_wdata,
  input  logic                                        d_mcause_int_wmask,
  input  logic                                        d_trap_exception,
  input  logic [trace_monitor_pkg::CAUSE_W-1:0]       d_trap_exc_cause,
  input  logic                                        d_trap_debug,
  input  logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   d_trap_dbg_cause,
  input  logic                                        d_intr_interrupt,
  input  logic                                        d_intr_exception,
  input  logic [trace_monitor_pkg::CAUSE_W-1:0]       d_intr_cause,
  input  logic [trace_monitor_pkg::MASK_W-1:0]        d_mem_wmask,
  input  logic                                        d_is_store,
  input  logic [trace_monitor_pkg::CAUSE_W-1:0]       d_exccode,
  input  logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   d_dcsr_cause,
  output logic [trace_monitor_pkg::V_STORE_MASK:0]    rule_viol
);
  import trace_monitor_pkg::*;

  // Highest CLIC identifier
  localparam int unsigned max_clic_id = (2 ** clic_id_width) - 1;

  // History of earlier records
  logic first_after_reset;
  logic was_dbg_mode;
  logic prev_exception;

  logic                 exc_outside_dbg;
  logic                 rs_nonzero;
  logic                 cause_legal;
  logic [V_STORE_MASK:0] viol_c;

  // Reset marks the next record as the first one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_after_reset <= 1'b1;
      was_dbg_mode      <= 1'b0;
      prev_exception    <= 1'b0;
    end else if (d_valid) begin
      first_after_reset <= 1'b0;
      was_dbg_mode      <= d_dbg_mode;
      prev_exception    <= d_trap_exception;
    end
  end

  // Register reads that must see reset values
  assign rs_nonzero = ((d_rs1_addr != '0) && (d_rs1_rdata != '0)) ||
                      ((d_rs2_addr != '0) && (d_rs2_rdata != '0));

  // mcause is only written for exceptions taken outside debug
  assign exc_outside_dbg = d_trap_exception && !d_dbg_mode;

  // Legal set depends on the interrupt scheme
  always_comb begin
    cause_legal = d_intr_cause inside {[PLAT_CAUSE_LO:PLAT_CAUSE_HI]};
    if (clic) begin
      cause_legal = cause_legal || (int'(d_intr_cause) <= max_clic_id);
    end else begin
      cause_legal = cause_legal ||
                    (d_intr_cause inside {CLINT_CAUSE_MSI, CLINT_CAUSE_MTI, CLINT_CAUSE_MEI,
                                          [CLINT_FAST_LO:CLINT_FAST_HI]});
    end
  end

  // All rules, qualified by the record strobe
  always_comb begin
    viol_c = '0;
    viol_c[V_RS_RESET]  = first_after_reset && rs_nonzero;
    // Debug cause is checked only on entry to debug mode
    viol_c[V_DBG_CAUSE] = (d_dbg != '0) && !was_dbg_mode && (d_dbg != d_dcsr_cause);
    viol_c[V_EXC_CAUSE] = exc_outside_dbg && (d_trap_exc_cause != d_exccode);
    // Exceptions must write mcause.interrupt to zero
    viol_c[V_EXC_MCAUSE_INT]   = exc_outside_dbg && (!d_mcause_int_wmask || d_mcause_int_wdata);
    viol_c[V_IRQ_CAUSE]        = d_intr_interrupt && !cause_legal;
    viol_c[V_HANDLER_AMBIG]    = d_intr_exception && d_intr_interrupt;
    // A synchronous handler needs a trapping record before it
    viol_c[V_SYNC_UNANNOUNCED] = d_intr_exception && !d_intr_interrupt && !prev_exception;
    viol_c[V_MISSING_CAUSE]    = (d_trap_exception && (d_trap_exc_cause == '0)) ||
                                 (d_trap_debug && (d_trap_dbg_cause == '0));
    viol_c[V_STORE_MASK]       = (|d_mem_wmask) && !d_is_store;
    if (!d_valid) begin
      viol_c = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rule_viol <= '0;
    end else begin
      rule_viol <= viol_c;
    end
  end

endmodule

// ==== src/trace_event_counter.sv ====
`timescale 1ns/10ps

module trace_event_counter (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             bus_valid,
  input  logic                                             bus_ready,
  input  logic                                             irq_ack,
  input  logic                                             d_valid,
  input  logic [trace_monitor_pkg::MEM_CNT_W-1:0]          d_mem_cnt,
  input  logic                                             d_intr_interrupt,
  output logic [trace_monitor_pkg::V_IRQ_OVERREPORT:
                trace_monitor_pkg::V_MEM_OVERREPORT]       cnt_viol
);
  import trace_monitor_pkg::*;

  logic [CNT_W-1:0] bus_cnt, bus_cnt_nxt;
  logic [CNT_W-1:0] mem_cnt, mem_cnt_nxt;
  logic [CNT_W-1:0] ack_cnt, ack_cnt_nxt;
  logic [CNT_W-1:0] irq_cnt, irq_cnt_nxt;

  // Add with saturation at the counter maximum
  function automatic logic [CNT_W-1:0] sat_add(logic [CNT_W-1:0] cnt,
                                               logic [MEM_CNT_W-1:0] inc);
    logic [CNT_W:0] sum;
    sum = {1'b0, cnt} + (CNT_W + 1)'(inc);
    return sum[CNT_W] ? '1 : sum[CNT_W-1:0];
  endfunction

  // Handshakes and acks seen on the core side
  assign bus_cnt_nxt = sat_add(bus_cnt, MEM_CNT_W'(bus_valid && bus_ready));
  assign ack_cnt_nxt = sat_add(ack_cnt, MEM_CNT_W'(irq_ack));

  // Events that the trace claims
  assign mem_cnt_nxt = sat_add(mem_cnt, d_valid ? d_mem_cnt : '0);
  assign irq_cnt_nxt = sat_add(irq_cnt, MEM_CNT_W'(d_valid && d_intr_interrupt));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt  <= '0;
      mem_cnt  <= '0;
      ack_cnt  <= '0;
      irq_cnt  <= '0;
      cnt_viol <= '0;
    end else begin
      bus_cnt <= bus_cnt_nxt;
      mem_cnt <= mem_cnt_nxt;
      ack_cnt <= ack_cnt_nxt;
      irq_cnt <= irq_cnt_nxt;
      // Compare updated totals so the flag lands with the counts
      cnt_viol[V_MEM_OVERREPORT] <= mem_cnt_nxt > bus_cnt_nxt;
      cnt_viol[V_IRQ_OVERREPORT] <= irq_cnt_nxt > ack_cnt_nxt;
    end
  end

endmodule

// ==== src/trace_error_log.sv ====
`timescale 1ns/10ps

module trace_error_log (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic [trace_monitor_pkg::V_STORE_MASK:0]         rule_viol,
  input  logic [trace_monitor_pkg::V_IRQ_OVERREPORT:
                trace_monitor_pkg::V_MEM_OVERREPORT]       cnt_viol,
  output logic [trace_monitor_pkg::NUM_VIOL-1:0]           err_flags,
  output logic [trace_monitor_pkg::VIOL_CODE_W-1:0]        first_code,
  output logic                                             err_any
);
  import trace_monitor_pkg::*;

  logic [NUM_VIOL-1:0]    viol;
  logic [VIOL_CODE_W-1:0] low_code;

  // Counter bits sit above the rule bits
  assign viol = {cnt_viol, rule_viol};

  // Lowest set index, scanning down so the last hit wins
  always_comb begin
    low_code = '0;
    for (int i = NUM_VIOL - 1; i >= 0; i--) begin
      if (viol[i]) begin
        low_code = VIOL_CODE_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_flags  <= '0;
      first_code <= '0;
      err_any    <= 1'b0;
    end else begin
      // Flags only accumulate until reset
      err_flags <= err_flags | viol;
      // Code is frozen after the first violating cycle
      if (!err_any && (|viol)) begin
        first_code <= low_code;
        err_any    <= 1'b1;
      end
    end
  end

endmodule

// ==== src/trace_monitor.sv ====
`timescale 1ns/10ps

module trace_monitor #(
  parameter bit          clic          = 1'b0,
  parameter int unsigned clic_id_width = 5
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        rec_valid,
  input  logic [trace_monitor_pkg::REG_ADDR_W-1:0]    rec_rs1_addr,
  input  logic [trace_monitor_pkg::REG_ADDR_W-1:0]    rec_rs2_addr,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_rs1_rdata,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_rs2_rdata,
  input  logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   rec_dbg,
  input  logic                                        rec_dbg_mode,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_dcsr_rdata,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_mcause_wdata,
  input  logic [trace_monitor_pkg::XLEN-1:0]          rec_mcause_wmask,
  input  logic                                        rec_trap_exception,
  input  logic [trace_monitor_pkg::CAUSE_W-1:0]       rec_trap_exc_cause,
  input  logic                                        rec_trap_debug,
  input  logic [trace_monitor_pkg::DBG_CAUSE_W-1:0]   rec_trap_dbg_cause,
  input  logic                                        rec_intr_interrupt,
  input  logic                                        rec_intr_exception,
  input  logic [trace_monitor_pkg::CAUSE_W-1:0]       rec_intr_cause,
  input  logic [trace_monitor_pkg::MASK_W-1:0]        rec_mem_rmask,
  input  logic [trace_monitor_pkg::MASK_W-1:0]        rec_mem_wmask,
  input  logic                                        rec_is_store,
  input  logic                                        bus_valid,
  input  logic                                        bus_ready,
  input  logic                                        irq_ack,
  output logic [trace_monitor_pkg::NUM_VIOL-1:0]      err_flags,
  output logic [trace_monitor_pkg::VIOL_CODE_W-1:0]   first_code,
  output logic                                        err_any
);
  import trace_monitor_pkg::*;

  // Decode stage outputs
  logic                   d_valid;
  logic [REG_ADDR_W-1:0]  d_rs1_addr, d_rs2_addr;
  logic [XLEN-1:0]        d_rs1_rdata, d_rs2_rdata;
  logic [DBG_CAUSE_W-1:0] d_dbg, d_trap_dbg_cause, d_dcsr_cause;
  logic                   d_dbg_mode, d_mcause_int_wdata, d_mcause_int_wmask;
  logic                   d_trap_exception, d_trap_debug;
  logic                   d_intr_interrupt, d_intr_exception, d_is_store;
  logic [CAUSE_W-1:0]     d_trap_exc_cause, d_intr_cause, d_exccode;
  logic [MASK_W-1:0]      d_mem_wmask;
  logic [MEM_CNT_W-1:0]   d_mem_cnt;

  // Execute stage violations
  logic [V_STORE_MASK:0]                    rule_viol;
  logic [V_IRQ_OVERREPORT:V_MEM_OVERREPORT] cnt_viol;

  trace_decode i_decode (
    .clk_i, .rst_ni,
    .rec_valid, .rec_rs1_addr, .rec_rs2_addr, .rec_rs1_rdata, .rec_rs2_rdata,
    .rec_dbg, .rec_dbg_mode, .rec_dcsr_rdata, .rec_mcause_wdata, .rec_mcause_wmask,
    .rec_trap_exception, .rec_trap_exc_cause, .rec_trap_debug, .rec_trap_dbg_cause,
    .rec_intr_interrupt, .rec_intr_exception, .rec_intr_cause,
    .rec_mem_rmask, .rec_mem_wmask, .rec_is_store,
    .d_valid, .d_rs1_addr, .d_rs2_addr, .d_rs1_rdata, .d_rs2_rdata,
    .d_dbg, .d_dbg_mode, .d_mcause_int_wdata, .d_mcause_int_wmask,
    .d_trap_exception, .d_trap_exc_cause, .d_trap_debug, .d_trap_dbg_cause,
    .d_intr_interrupt, .d_intr_exception, .d_intr_cause,
    .d_mem_wmask, .d_is_store, .d_exccode, .d_dcsr_cause, .d_mem_cnt
  );

  trace_rule_check #(
    .clic          (clic),
    .clic_id_width (clic_id_width)
  ) i_rule_check (
    .clk_i, .rst_ni,
    .d_valid, .d_rs1_addr, .d_rs2_addr, .d_rs1_rdata, .d_rs2_rdata,
    .d_dbg, .d_dbg_mode, .d_mcause_int_wdata, .d_mcause_int_wmask,
    .d_trap_exception, .d_trap_exc_cause, .d_trap_debug, .d_trap_dbg_cause,
    .d_intr_interrupt, .d_intr_exception, .d_intr_cause,
    .d_mem_wmask, .d_is_store, .d_exccode, .d_dcsr_cause,
    .rule_viol
  );

  trace_event_counter i_event_counter (
    .clk_i, .rst_ni,
    .bus_valid, .bus_ready, .irq_ack,
    .d_valid, .d_mem_cnt, .d_intr_interrupt,
    .cnt_viol
  );

  // Result stage
  trace_error_log i_error_log (
    .clk_i, .rst_ni,
    .rule_viol, .cnt_viol,
    .err_flags, .first_code, .err_any
  );

endmodule

// ==== verification/trace_monitor_checker.sv ====
`timescale 1ns/10ps

module trace_monitor_checker (
  input logic                                        clk_i,
  input logic                                        rst_ni,
  input logic [trace_monitor_pkg::NUM_VIOL-1:0]      err_flags,
  input logic [trace_monitor_pkg::VIOL_CODE_W-1:0]   first_code,
  input logic                                        err_any
);

  // Number of failed properties, read by the testbench at the end
  int unsigned fail_count = 0;

  // Sticky flags never drop a bit
  flags_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (err_flags & $past(err_flags)) == $past(err_flags))
    else begin
      $error("err_flags lost a bit");
      fail_count++;
    end

  // Summary level follows the flag vector
  any_matches_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_any == (|err_flags))
    else begin
      $error("err_any differs from the OR of err_flags");
      fail_count++;
    end

  // First code frozen once an error was logged
  code_frozen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(err_any) |-> $stable(first_code))
    else begin
      $error("first_code changed after err_any was set");
      fail_count++;
    end

  // First log update after reset release sees only reset upstream state
  clean_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |=> err_flags == '0)
    else begin
      $error("err_flags set in the cycle after reset");
      fail_count++;
    end

endmodule

bind trace_monitor trace_monitor_checker i_checker (
  .clk_i, .rst_ni, .err_flags, .first_code, .err_any
);

// ==== verification/trace_monitor_tb.sv ====
`timescale 1ns/10ps

module trace_monitor_tb;
  import trace_monitor_pkg::*;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   rec_valid;
  logic [REG_ADDR_W-1:0]  rec_rs1_addr, rec_rs2_addr;
  logic [XLEN-1:0]        rec_rs1_rdata, rec_rs2_rdata;
  logic [DBG_CAUSE_W-1:0] rec_dbg, rec_trap_dbg_cause;
  logic                   rec_dbg_mode, rec_trap_exception, rec_trap_debug;
  logic [XLEN-1:0]        rec_dcsr_rdata, rec_mcause_wdata, rec_mcause_wmask;
  logic [CAUSE_W-1:0]     rec_trap_exc_cause, rec_intr_cause;
  logic                   rec_intr_interrupt, rec_intr_exception, rec_is_store;
  logic [MASK_W-1:0]      rec_mem_rmask, rec_mem_wmask;
  logic                   bus_valid, bus_ready, irq_ack;
  logic [NUM_VIOL-1:0]    err_flags;
  logic [VIOL_CODE_W-1:0] first_code;
  logic                   err_any;

  // Stimulus state
  logic [15:0] lfsr = 16'd65405;
  int unsigned bus_credit;
  logic        last_trap;

  // Reference model state
  logic                    ref_first, ref_dbg_mode, ref_prev_exc;
  logic [V_STORE_MASK:0]   rule_p, rule_q;
  logic [1:0]              cnt_q;
  int unsigned             bus_ref, ack_ref, mem_ref, irq_ref, pend_mem;
  logic                    pend_irq;
  logic [NUM_VIOL-1:0]     viol_in, exp_flags;
  logic [VIOL_CODE_W-1:0]  exp_code;
  logic                    exp_any;

  trace_monitor #(
    .clic          (1'b0),
    .clic_id_width (5)
  ) i_dut (.*);

  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  // Galois LFSR, one step per returned bit
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // CLINT set plus platform causes
  function automatic bit legal_irq_cause(input logic [CAUSE_W-1:0] c);
    return (c == 3) || (c == 7) || (c == 11) || (c >= 16 && c <= 31) ||
           (c >= 1024 && c <= 1027);
  endfunction

  // Expected rule bits of the record on the inputs, updates history
  function automatic logic [V_STORE_MASK:0] expected_rules();
    logic [V_STORE_MASK:0] v;
    logic [XLEN-1:0]       code;
    logic                  exc;
    v = '0;
    if (rec_valid) begin
      code = rec_mcause_wdata & rec_mcause_wmask;
      exc  = rec_trap_exception && !rec_dbg_mode;
      v[V_RS_RESET] = ref_first && ((rec_rs1_addr != 0 && rec_rs1_rdata != 0) ||
                                    (rec_rs2_addr != 0 && rec_rs2_rdata != 0));
      v[V_DBG_CAUSE] = rec_dbg != 0 && !ref_dbg_mode && rec_dbg != rec_dcsr_rdata[8:6];
      v[V_EXC_CAUSE] = exc && rec_trap_exc_cause != code[10:0];
      v[V_EXC_MCAUSE_INT] = exc && (!rec_mcause_wmask[31] || rec_mcause_wdata[31]);
      v[V_IRQ_CAUSE] = rec_intr_interrupt && !legal_irq_cause(rec_intr_cause);
      v[V_HANDLER_AMBIG] = rec_intr_exception && rec_intr_interrupt;
      v[V_SYNC_UNANNOUNCED] = rec_intr_exception && !rec_intr_interrupt && !ref_prev_exc;
      v[V_MISSING_CAUSE] = (rec_trap_exception && rec_trap_exc_cause == 0) ||
                           (rec_trap_debug && rec_trap_dbg_cause == 0);
      v[V_STORE_MASK] = rec_mem_wmask != 0 && !rec_is_store;
      ref_first    = 1'b0;
      ref_dbg_mode = rec_dbg_mode;
      ref_prev_exc = rec_trap_exception;
    end
    return v;
  endfunction

  function automatic int lowest_index(input logic [NUM_VIOL-1:0] v);
    for (int i = 0; i < NUM_VIOL; i++) begin
      if (v[i]) begin
        return i;
      end
    end
    return 0;
  endfunction

  // Model of the expected log, rule bits two edges late, counter bits one
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {ref_dbg_mode, ref_prev_exc, pend_irq, exp_any} = '0;
      ref_first = 1'b1;
      {rule_p, rule_q, cnt_q, exp_flags, exp_code} = '0;
      {bus_ref, ack_ref, mem_ref, irq_ref, pend_mem} = '0;
    end else begin
      viol_in   = {cnt_q, rule_q};
      exp_flags = exp_flags | viol_in;
      if (!exp_any && viol_in != 0) begin
        exp_code = VIOL_CODE_W'(lowest_index(viol_in));
        exp_any  = 1'b1;
      end
      rule_q = rule_p;
      rule_p = expected_rules();
      // Real events count at once, reported ones a cycle later
      bus_ref  = bus_ref + int'(bus_valid && bus_ready);
      ack_ref  = ack_ref + int'(irq_ack);
      mem_ref  = mem_ref + pend_mem;
      irq_ref  = irq_ref + int'(pend_irq);
      cnt_q    = {irq_ref > ack_ref, mem_ref > bus_ref};
      pend_mem = rec_valid ? int'(rec_mem_rmask != 0) + int'(rec_mem_wmask != 0) : 0;
      pend_irq = rec_valid && rec_intr_interrupt;
    end
  end

  // Outputs compared half a cycle after each update
  always @(negedge clk_i) begin
    if (rst_ni) begin
      assert (err_flags == exp_flags)
        else fail_run($sformatf("FAILED at %0d ns: err_flags %b, expected %b",
                                $time, err_flags, exp_flags));
      assert (err_any == exp_any)
        else fail_run($sformatf("FAILED at %0d ns: err_any %b, expected %b",
                                $time, err_any, exp_any));
      assert (first_code == exp_code)
        else fail_run($sformatf("FAILED at %0d ns: first_code %0d, expected %0d",
                                $time, first_code, exp_code));
    end
  end

  task automatic clear_inputs();
    {rec_valid, rec_rs1_addr, rec_rs2_addr, rec_rs1_rdata, rec_rs2_rdata} = '0;
    {rec_dbg, rec_dbg_mode, rec_dcsr_rdata, rec_mcause_wdata, rec_mcause_wmask} = '0;
    {rec_trap_exception, rec_trap_exc_cause, rec_trap_debug, rec_trap_dbg_cause} = '0;
    {rec_intr_interrupt, rec_intr_exception, rec_intr_cause} = '0;
    {rec_mem_rmask, rec_mem_wmask, rec_is_store, bus_valid, bus_ready, irq_ack} = '0;
  endtask

  // Hold the driven record for one cycle
  task automatic send();
    @(negedge clk_i);
    clear_inputs();
  endtask

  task automatic settle(input int unsigned n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    clear_inputs();
    settle(3);
    rst_ni = 1'b1;
  endtask

  task automatic expect_log(input logic [NUM_VIOL-1:0] flags, input int code);
    int cycles;
    cycles = 0;
    while (!err_any) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 20) begin
        fail_run("timeout: err_any never rose after the injected violation");
      end
    end
    // Later records of the same case may still land
    settle(3);
    assert (err_flags == flags && first_code == code)
      else fail_run($sformatf("FAILED at %0d ns: flags %b code %0d, expected %b code %0d",
                              $time, err_flags, first_code, flags, code));
  endtask

  // Legal record with consistent causes and covered accesses
  task automatic random_record();
    logic [2:0] sel;
    bus_valid = lfsr_bits(1);
    bus_ready = 1'b1;
    bus_credit += int'(bus_valid);
    rec_valid     = 1'b1;
    rec_rs1_addr  = lfsr_bits(REG_ADDR_W);
    rec_rs2_addr  = lfsr_bits(REG_ADDR_W);
    rec_rs1_rdata = lfsr_bits(XLEN);
    rec_rs2_rdata = lfsr_bits(XLEN);
    rec_dbg_mode  = lfsr_bits(1);
    rec_dbg       = lfsr_bits(DBG_CAUSE_W);
    rec_dcsr_rdata = (lfsr_bits(XLEN) & ~32'h0000_01C0) | (32'(rec_dbg) << 6);
    rec_trap_exception = lfsr_bits(1);
    rec_trap_exc_cause = CAUSE_W'(1 + lfsr_bits(4));
    rec_mcause_wdata   = 32'(rec_trap_exc_cause);
    rec_mcause_wmask   = 32'hFFFF_FFFF;
    rec_trap_debug     = lfsr_bits(1);
    rec_trap_dbg_cause = {lfsr_bits(2), 1'b1};
    rec_intr_interrupt = lfsr_bits(1);
    irq_ack            = rec_intr_interrupt;
    sel = lfsr_bits(3);
    case (sel)
      3'd0: rec_intr_cause = 11'd3;
      3'd1: rec_intr_cause = 11'd7;
      3'd2: rec_intr_cause = 11'd11;
      3'd3, 3'd4: rec_intr_cause = CAUSE_W'(16 + lfsr_bits(4));
      default: rec_intr_cause = CAUSE_W'(1024 + lfsr_bits(2));
    endcase
    // Synchronous handler only right after a trapping record
    rec_intr_exception = !rec_intr_interrupt && last_trap && lfsr_bits(1);
    if (bus_credit >= 2) begin
      rec_mem_rmask = lfsr_bits(MASK_W);
      rec_is_store  = lfsr_bits(1);
      rec_mem_wmask = rec_is_store ? lfsr_bits(MASK_W) : '0;
      bus_credit -= int'(rec_mem_rmask != 0) + int'(rec_mem_wmask != 0);
    end
    last_trap = rec_trap_exception;
    send();
  endtask

  // One rule broken on an otherwise empty record
  task automatic inject_rule(input int idx);
    clear_inputs();
    rec_valid = 1'b1;
    case (idx)
      V_RS_RESET: begin
        rec_rs1_addr  = 5'd1;
        rec_rs1_rdata = 32'h5;
      end
      V_DBG_CAUSE: rec_dbg = 3'd2;
      V_EXC_CAUSE, V_EXC_MCAUSE_INT: begin
        rec_trap_exception = 1'b1;
        rec_trap_exc_cause = 11'd5;
        rec_mcause_wdata   = (idx == V_EXC_CAUSE) ? 32'd6 : 32'd5;
        rec_mcause_wmask   = (idx == V_EXC_CAUSE) ? 32'hFFFF_FFFF : 32'h0000_07FF;
      end
      V_IRQ_CAUSE, V_HANDLER_AMBIG: begin
        rec_intr_interrupt = 1'b1;
        rec_intr_exception = (idx == V_HANDLER_AMBIG);
        rec_intr_cause     = (idx == V_HANDLER_AMBIG) ? 11'd7 : 11'd5;
        irq_ack            = 1'b1;
      end
      V_SYNC_UNANNOUNCED: rec_intr_exception = 1'b1;
      V_MISSING_CAUSE: rec_trap_debug = 1'b1;
      default: begin
        rec_mem_wmask = 4'h3;
        bus_valid     = 1'b1;
        bus_ready     = 1'b1;
      end
    endcase
    send();
  endtask

  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    clear_inputs();
    apply_reset();

    // Random legal traffic after an empty first record
    rec_valid = 1'b1;
    send();
    bus_credit = 0;
    last_trap  = 1'b0;
    for (int n = 0; n < 300; n++) begin
      random_record();
    end
    settle(4);
    assert (err_flags == '0 && !err_any)
      else fail_run($sformatf("FAILED at %0d ns: legal traffic logged flags %b",
                              $time, err_flags));

    // Each rule alone
    for (int idx = V_RS_RESET; idx <= V_STORE_MASK; idx++) begin
      apply_reset();
      inject_rule(idx);
      expect_log(NUM_VIOL'(1) << idx, idx);
    end

    // Debug cause ignored while already in debug mode
    apply_reset();
    rec_valid    = 1'b1;
    rec_dbg_mode = 1'b1;
    send();
    rec_valid = 1'b1;
    rec_dbg   = 3'd3;
    send();
    settle(4);
    assert (!err_any)
      else fail_run($sformatf("FAILED at %0d ns: debug cause flagged inside debug mode", $time));
    rec_valid = 1'b1;
    send();
    rec_valid = 1'b1;
    rec_dbg   = 3'd3;
    send();
    expect_log(NUM_VIOL'(1) << V_DBG_CAUSE, V_DBG_CAUSE);

    // Access and interrupt that never happened
    apply_reset();
    rec_valid     = 1'b1;
    rec_mem_rmask = 4'h1;
    send();
    expect_log(NUM_VIOL'(1) << V_MEM_OVERREPORT, V_MEM_OVERREPORT);
    apply_reset();
    rec_valid          = 1'b1;
    rec_intr_interrupt = 1'b1;
    rec_intr_cause     = 11'd3;
    send();
    expect_log(NUM_VIOL'(1) << V_IRQ_OVERREPORT, V_IRQ_OVERREPORT);

    // Earlier record names the code even with a higher index
    apply_reset();
    inject_rule(V_STORE_MASK);
    inject_rule(V_DBG_CAUSE);
    expect_log((NUM_VIOL'(1) << V_STORE_MASK) | (NUM_VIOL'(1) << V_DBG_CAUSE), V_STORE_MASK);
    apply_reset();
    assert (err_flags == '0 && first_code == '0 && !err_any)
      else fail_run($sformatf("FAILED at %0d ns: log not cleared by reset", $time));
    settle(2);

    if (i_dut.i_checker.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      fail_run("a bound checker property failed during the run");
    end
  end

endmodule

// ==== trace_monitor.f ====
src/trace_monitor_pkg.sv
src/trace_decode.sv
src/trace_rule_check.sv
src/trace_event_counter.sv
src/trace_error_log.sv
src/trace_monitor.sv
verification/trace_monitor_checker.sv
verification/trace_monitor_tb.sv
